//--- Makefile
TOP := inbound_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f files.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

//--- bench/inbound_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "inbound_settings.svh"

module inbound_tb;

    localparam int AW         = `INB_ADDR_W;
    localparam int NUM_PKTS   = 200;
    localparam int MAX_CYCLES = 40 * NUM_PKTS + 100;

    // indexed by BAR code, ROM at 6 and config at 7.
    localparam logic [AW-1:0] BAR_MASK [8] = '{
        `INB_BAR0_MASK, `INB_BAR1_MASK, `INB_BAR2_MASK, `INB_BAR3_MASK,
        `INB_BAR4_MASK, `INB_BAR5_MASK, `INB_ROM_MASK, `INB_CFG_MASK
    };
    localparam logic [AW-1:0] BAR_BASE [8] = '{
        `INB_BAR0_BASE, `INB_BAR1_BASE, `INB_BAR2_BASE, `INB_BAR3_BASE,
        `INB_BAR4_BASE, `INB_BAR5_BASE, `INB_ROM_BASE, `INB_CFG_BASE
    };

    logic          clk;
    logic          rst;
    logic          rx_valid;
    logic          rx_sof;
    logic          rx_eof;
    logic [31:0]   rx_data;
    logic [2:0]    rx_bar;
    logic          wr_valid;
    logic [AW-1:0] wr_addr;
    logic [31:0]   wr_data;

    logic [31:0]   lfsr = 32'hf795;
    logic [AW-1:0] exp_addr_q[$];
    logic [31:0]   exp_data_q[$];
    string         exp_name_q[$];
    bit            started = 1'b0;
    int            cycles = 0;

    inbound_top u_inbound_top (
        .clk      (clk),
        .rst      (rst),
        .rx_valid (rx_valid),
        .rx_sof   (rx_sof),
        .rx_eof   (rx_eof),
        .rx_data  (rx_data),
        .rx_bar   (rx_bar),
        .wr_valid (wr_valid),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string test, input logic [AW-1:0] ea,
                                   input logic [31:0] ed, input logic [AW-1:0] aa,
                                   input logic [31:0] ad);
        $display("** Error %s: expected addr %h data %h, actual addr %h data %h",
                 test, ea, ed, aa, ad);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    // one output bit per step, taken from the low end of a Galois register.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = 32'd0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [AW-1:0] expected_base(input logic [2:0] bar,
                                                    input logic [AW-1:0] a);
        logic [AW-1:0] r;
        r      = (a & BAR_MASK[bar]) | (BAR_BASE[bar] & ~BAR_MASK[bar]);
        r[1:0] = 2'b00;                  // the link address is dword aligned.
        return r;
    endfunction

    // kind 0 is a memory write, 1 a memory read, 2 an I/O write, 3 a config write, 4 a completion.
    task automatic send_packet(input int kind, input logic [2:0] bar, input logic four_dw,
                               input logic [63:0] addr, input int len, input bit gaps,
                               input string test);
        inbound_pkg::tlp_dw0_t dw0;
        inbound_pkg::tlp_dw2_u dw2;
        logic [31:0]           dws [0:7];
        logic [AW-1:0]         next_addr;
        int                    n;
        int                    i;
        int                    gap;
        dw0              = '0;
        dw0.length       = len[9:0];
        dw0.fmt.has_data = (kind != 1);
        dw0.fmt.is_4dw   = (kind <= 1) && four_dw;
        case (kind)
            0, 1: dw0.tlp_type = inbound_pkg::TLP_TYPE_MEM;
            2: dw0.tlp_type = inbound_pkg::TLP_TYPE_IO;
            3: dw0.tlp_type = inbound_pkg::TLP_TYPE_CFG0;
            default: dw0.tlp_type = inbound_pkg::TLP_TYPE_CPL;
        endcase
        dws[0] = dw0;
        dws[1] = rand_bits(32);
        if (dw0.fmt.is_4dw) begin
            dw2.addr_hi = addr[63:32];
            dws[2]      = dw2;
            dws[3]      = {addr[31:2], 2'b00};
            n           = 4;
        end else begin
            dw2.addr_lo.addr = addr[31:2];
            dw2.addr_lo.rsvd = 2'b00;
            dws[2]           = dw2;
            n                = 3;
        end
        next_addr = expected_base(bar, addr[AW-1:0]);
        if (dw0.fmt.has_data) begin
            for (i = 0; i < len; i++) begin
                dws[n + i] = rand_bits(32);
                if (kind == 0) begin
                    exp_addr_q.push_back(next_addr);
                    exp_data_q.push_back(dws[n + i]);
                    exp_name_q.push_back(test);
                    next_addr = next_addr + AW'(4);
                end
            end
            n = n + len;
        end
        started = 1'b1;
        for (i = 0; i < n; i++) begin
            gap = gaps ? (rand_bits(1) ? 0 : int'(rand_bits(2))) : 0;
            repeat (gap) begin
                @(posedge clk);
                rx_valid <= 1'b0;
            end
            @(posedge clk);
            rx_valid <= 1'b1;
            rx_sof   <= (i == 0);
            rx_eof   <= (i == n - 1);
            rx_data  <= dws[i];
            rx_bar   <= bar;
        end
    endtask

    idle_after_reset: assert property (@(posedge clk) disable iff (rst) !started |-> !wr_valid)
        else stop_run("wr_valid rose before any packet was sent");

    always @(posedge clk) begin
        logic [AW-1:0] ea;
        logic [31:0]   ed;
        string         name;
        if (!rst && wr_valid) begin
            if (exp_addr_q.size() == 0) begin
                stop_run("a local bus write appeared with no write expected");
            end else begin
                ea   = exp_addr_q.pop_front();
                ed   = exp_data_q.pop_front();
                name = exp_name_q.pop_front();
                assert (wr_addr == ea && wr_data == ed)
                    else report_mismatch(name, ea, ed, wr_addr, wr_data);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            stop_run("timeout: the run did not finish within the cycle limit");
        end
    end

    initial begin
        int b;
        int k;
        rst      <= 1'b1;
        rx_valid <= 1'b0;
        rx_sof   <= 1'b0;
        rx_eof   <= 1'b0;
        rx_data  <= 32'd0;
        rx_bar   <= 3'd0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        repeat (10) @(posedge clk);
        for (b = 0; b < 8; b++) begin
            send_packet(0, 3'(b), 1'b0, {32'd0, rand_bits(32)}, 1, 1'b0, "bar_sweep");
        end
        for (b = 0; b < 8; b++) begin
            send_packet(0, 3'(b), 1'b1, {rand_bits(32), rand_bits(32)},
                        int'(rand_bits(2)) + 1, 1'b0, "addr_4dw");
        end
        for (b = 0; b < 8; b++) begin
            send_packet(0, 3'(b), 1'b0, {32'd0, rand_bits(32)}, 4, 1'b0, "burst");
        end
        for (k = 24; k < NUM_PKTS; k++) begin
            b = int'(rand_bits(3));          // half of them are memory writes.
            send_packet((b <= 3) ? 0 : b - 3, 3'(rand_bits(3)), rand_bits(1) != 0,
                        {rand_bits(32), rand_bits(32)}, int'(rand_bits(2)) + 1,
                        k >= 112, (k >= 112) ? "mixed_gaps" : "mixed_b2b");
        end
        @(posedge clk);
        rx_valid <= 1'b0;
        rx_sof   <= 1'b0;
        rx_eof   <= 1'b0;
        repeat (8) @(posedge clk);           // writes trail their payload dword by two cycles.
        if (exp_addr_q.size() == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            stop_run("expected writes were still missing at the end of the run");
        end
    end

endmodule

`default_nettype wire

//--- design/inbound_hdr_parse.sv
`timescale 1ns/1ps
`default_nettype none

module inbound_hdr_parse (
    input  wire         clk,
    input  wire         rst,
    input  wire         rx_valid,
    input  wire         rx_sof,
    input  wire         rx_eof,
    input  wire  [31:0] rx_data,
    input  wire  [2:0]  rx_bar,
    trans_if.requester  trans,
    output logic        pay_valid,
    output logic        pay_first,
    output logic        pay_last,
    output logic [31:0] pay_data
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_HDR,
        S_PAY,
        S_DROP
    } state_t;

    state_t                 state;
    logic [1:0]             hdr_cnt;
    logic                   is_wr;
    logic                   first;
    logic                   hdr_last;
    inbound_pkg::tlp_dw0_t  dw0;
    inbound_pkg::tlp_dw2_u  dw2;

    assign dw0 = rx_data;
    assign dw2 = rx_data;            // dword 3 of a 4-DW header uses the same low view.

    assign hdr_last = (hdr_cnt == 2'd3) || (hdr_cnt == 2'd2 && !trans.is64);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            hdr_cnt   <= 2'd0;
            first     <= 1'b0;
            trans.req <= 1'b0;
            pay_valid <= 1'b0;
        end else begin
            trans.req <= 1'b0;
            pay_valid <= 1'b0;
            if (rx_valid) begin
                case (state)
                    S_IDLE: begin
                        if (rx_sof && !rx_eof) begin
                            hdr_cnt <= 2'd1;
                            state   <= S_HDR;
                        end
                    end
                    S_HDR: begin
                        hdr_cnt <= hdr_cnt + 2'd1;
                        if (rx_eof) begin
                            state <= S_IDLE;           // a header cut short is dropped.
                        end else if (hdr_last) begin
                            state     <= is_wr ? S_PAY : S_DROP;
                            trans.req <= is_wr;
                            first     <= 1'b1;
                        end
                    end
                    S_PAY: begin
                        pay_valid <= 1'b1;
                        first     <= 1'b0;
                        if (rx_eof) begin
                            state <= S_IDLE;
                        end
                    end
                    default: begin
                        if (rx_eof) begin
                            state <= S_IDLE;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid && state == S_IDLE && rx_sof) begin
            trans.is64 <= dw0.fmt.is_4dw;
            trans.bar  <= rx_bar;
            is_wr      <= dw0.fmt.has_data && (dw0.tlp_type == inbound_pkg::TLP_TYPE_MEM);
        end
        if (rx_valid && state == S_HDR) begin
            if (hdr_cnt == 2'd2 && trans.is64) begin
                trans.addr[63:32] <= dw2.addr_hi;
            end
            if (hdr_last) begin
                trans.addr[31:2] <= dw2.addr_lo.addr;
            end
        end
        if (rx_valid && state == S_PAY) begin
            pay_data  <= rx_data;
            pay_first <= first;
            pay_last  <= rx_eof;
        end
    end

endmodule

`default_nettype wire

//--- design/inbound_pkg.sv
`default_nettype none

package inbound_pkg;

    typedef struct packed {
        logic rsvd;
        logic has_data;                  // set for writes and completions with data.
        logic is_4dw;                    // set when the header carries a 64-bit address.
    } tlp_fmt_t;

    // length of zero encodes a full 1024-dword payload.
    typedef struct packed {
        tlp_fmt_t   fmt;
        logic [4:0] tlp_type;
        logic       rsvd_a;
        logic [2:0] tc;
        logic [3:0] rsvd_b;
        logic       td;
        logic       ep;
        logic [1:0] attr;
        logic [1:0] at;
        logic [9:0] length;
    } tlp_dw0_t;

    typedef struct packed {
        logic [31:2] addr;
        logic [1:0]  rsvd;
    } tlp_addr_lo_t;

    // dword 2 is the low address of a 3-DW header or the high address of a 4-DW header.
    typedef union packed {
        tlp_addr_lo_t addr_lo;
        logic [31:0]  addr_hi;
    } tlp_dw2_u;

    localparam logic [4:0] TLP_TYPE_MEM  = 5'b00000;
    localparam logic [4:0] TLP_TYPE_IO   = 5'b00010;
    localparam logic [4:0] TLP_TYPE_CFG0 = 5'b00100;
    localparam logic [4:0] TLP_TYPE_CPL  = 5'b01010;

endpackage

`default_nettype wire

//--- design/inbound_settings.svh
`ifndef INBOUND_SETTINGS_SVH
`define INBOUND_SETTINGS_SVH

// width of the local bus address.
`define INB_ADDR_W 32

// 4 KB register window.
`define INB_BAR0_MASK 32'h0000_0fff
`define INB_BAR0_BASE 32'h4000_0000

`define INB_BAR1_MASK 32'h0000_ffff
`define INB_BAR1_BASE 32'h4001_0000

`define INB_BAR2_MASK 32'h000f_ffff
`define INB_BAR2_BASE 32'h4010_0000

`define INB_BAR3_MASK 32'h0000_03ff
`define INB_BAR3_BASE 32'h4020_0400

`define INB_BAR4_MASK 32'h00ff_ffff
`define INB_BAR4_BASE 32'h5000_0000

// BAR5 passes the address straight through.
`define INB_BAR5_MASK 32'hffff_ffff
`define INB_BAR5_BASE 32'h0000_0000

// base bits under the mask are ignored by the translator.
`define INB_ROM_MASK  32'h0000_7fff
`define INB_ROM_BASE  32'h6000_8000

`define INB_CFG_MASK  32'h0000_00ff
`define INB_CFG_BASE  32'h7000_0000

`endif

//--- design/inbound_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "inbound_settings.svh"

module inbound_top (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     rx_valid,
    input  wire                     rx_sof,
    input  wire                     rx_eof,
    input  wire  [31:0]             rx_data,
    input  wire  [2:0]              rx_bar,
    output logic                    wr_valid,
    output logic [`INB_ADDR_W-1:0]  wr_addr,
    output logic [31:0]             wr_data
);

    logic        pay_valid;
    logic        pay_first;
    logic        pay_last;
    logic [31:0] pay_data;

    trans_if trans_bus ();

    inbound_hdr_parse u_hdr_parse (
        .clk       (clk),
        .rst       (rst),
        .rx_valid  (rx_valid),
        .rx_sof    (rx_sof),
        .rx_eof    (rx_eof),
        .rx_data   (rx_data),
        .rx_bar    (rx_bar),
        .trans     (trans_bus.requester),
        .pay_valid (pay_valid),
        .pay_first (pay_first),
        .pay_last  (pay_last),
        .pay_data  (pay_data)
    );

    inbound_trans u_trans (
        .clk   (clk),
        .rst   (rst),
        .trans (trans_bus.translator)
    );

    inbound_wr_engine u_wr_engine (
        .clk       (clk),
        .rst       (rst),
        .pay_valid (pay_valid),
        .pay_first (pay_first),
        .pay_last  (pay_last),
        .pay_data  (pay_data),
        .trans     (trans_bus.consumer),
        .wr_valid  (wr_valid),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

endmodule

`default_nettype wire

//--- design/inbound_trans.sv
`timescale 1ns/1ps
`default_nettype none

`include "inbound_settings.svh"

module inbound_trans (
    input  wire          clk,
    input  wire          rst,
    trans_if.translator  trans
);

    localparam int AW = `INB_ADDR_W;

    logic [AW-1:0] mask_full;
    logic [AW-1:0] base_full;
    logic [AW-1:2] mask;
    logic [AW-1:2] base;

    always_comb begin
        case (trans.bar)
            3'd0: begin
                mask_full = `INB_BAR0_MASK;
                base_full = `INB_BAR0_BASE;
            end
            3'd1: begin
                mask_full = `INB_BAR1_MASK;
                base_full = `INB_BAR1_BASE;
            end
            3'd2: begin
                mask_full = `INB_BAR2_MASK;
                base_full = `INB_BAR2_BASE;
            end
            3'd3: begin
                mask_full = `INB_BAR3_MASK;
                base_full = `INB_BAR3_BASE;
            end
            3'd4: begin
                mask_full = `INB_BAR4_MASK;
                base_full = `INB_BAR4_BASE;
            end
            3'd5: begin
                mask_full = `INB_BAR5_MASK;
                base_full = `INB_BAR5_BASE;
            end
            3'd6: begin
                mask_full = `INB_ROM_MASK;
                base_full = `INB_ROM_BASE;
            end
            default: begin
                mask_full = `INB_CFG_MASK;
                base_full = `INB_CFG_BASE;
            end
        endcase
    end

    assign mask = mask_full[AW-1:2];
    assign base = base_full[AW-1:2] & ~mask;

    always_ff @(posedge clk) begin
        trans.ack_addr <= (trans.addr[AW-1:2] & mask) | base;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            trans.ack <= 1'b0;
        end else begin
            trans.ack <= trans.req;
        end
    end

endmodule

`default_nettype wire

//--- design/inbound_wr_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "inbound_settings.svh"

module inbound_wr_engine (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     pay_valid,
    input  wire                     pay_first,
    input  wire                     pay_last,
    input  wire  [31:0]             pay_data,
    trans_if.consumer               trans,
    output logic                    wr_valid,
    output logic [`INB_ADDR_W-1:0]  wr_addr,
    output logic [31:0]             wr_data
);

    localparam int AW = `INB_ADDR_W;

    logic [AW-1:2] pend_addr;
    logic [AW-1:2] run_addr;
    logic [AW-1:2] start_addr;
    logic          in_pkt;
    logic          take;

    // the ack may land in the same cycle as its own first payload dword.
    assign start_addr = trans.ack ? trans.ack_addr : pend_addr;

    // stray dwords outside an open packet are not written.
    assign take = pay_valid && (pay_first || in_pkt);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_valid <= 1'b0;
            in_pkt   <= 1'b0;
        end else begin
            wr_valid <= take;
            if (pay_valid && pay_first) begin
                in_pkt <= !pay_last;
            end else if (pay_valid && pay_last) begin
                in_pkt <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (trans.ack) begin
            pend_addr <= trans.ack_addr;     // held for an overlapping packet.
        end
        if (take) begin
            wr_data <= pay_data;
            if (pay_first) begin
                wr_addr  <= {start_addr, 2'b00};
                run_addr <= start_addr + (AW-2)'(1);
            end else begin
                wr_addr  <= {run_addr, 2'b00};
                run_addr <= run_addr + (AW-2)'(1);   // one dword is four bytes.
            end
        end
    end

endmodule

`default_nettype wire

//--- design/trans_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "inbound_settings.svh"

interface trans_if;

    logic                     req;
    logic [2:0]               bar;
    logic [63:2]              addr;
    logic                     is64;           // upper address half is meaningful only when set.
    logic                     ack;
    logic [`INB_ADDR_W-1:2]   ack_addr;

    modport requester (output req, bar, addr, is64);

    modport translator (input req, bar, addr, is64, output ack, ack_addr);

    modport consumer (input ack, ack_addr);

endinterface

`default_nettype wire

//--- files.f
+incdir+design
design/inbound_pkg.sv
design/trans_if.sv
design/inbound_hdr_parse.sv
design/inbound_trans.sv
design/inbound_wr_engine.sv
design/inbound_top.sv
bench/inbound_tb.sv
